// ==== flist.f ====
logic/mem_pkg.sv
logic/mem_sequencer.sv
logic/sram_port.sv
logic/word_assembler.sv
logic/mem_stage_reg.sv
logic/mem_stage_top.sv
test/sram_model.sv
test/mem_stage_properties.sv
test/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/100ps
TOP       := tb_mem_stage
FLIST     := flist.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage import mem_pkg::*; ();

    typedef enum logic [1:0] {kind_alu, kind_store, kind_load} kind_t;

    typedef struct packed {
        kind_t                   kind;
        logic [reg_len-1:0]      alu_res;
        logic [reg_len-1:0]      val_rm;
        logic [reg_addr_len-1:0] dest;
        logic                    wb_en;
        int                      extra;  // Extra freeze cycles
    } row_t;

    localparam logic [reg_len-1:0] open_val = 32'hffff_ffff;  // Filled at random

    logic                     clk;
    logic                     reset;
    logic                     extra_freeze;
    logic                     freeze;
    stage_in_t                stage_in;
    stage_out_t               stage_out;
    hazard_t                  hazard;
    logic                     ready;
    sram_pins_t               sram;
    wire  [sram_data_len-1:0] sram_dq;

    row_t                     rows[$];
    string                    names[$];
    logic [reg_len-1:0]       shadow[logic [16:0]];  // Word memory by word index
    stage_out_t               exp_prev;
    logic [reg_len-1:0]       last_load;
    logic [reg_len-1:0]       last_store_addr;
    int                       errors;
    int                       row_errors;
    int                       cycle_limit;

    // Pipeline stalls the stage while it is busy
    assign freeze = extra_freeze || (ready === 1'b0);

    mem_stage_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .freeze    (freeze),
        .stage_in  (stage_in),
        .stage_out (stage_out),
        .hazard    (hazard),
        .ready     (ready),
        .sram      (sram),
        .sram_dq   (sram_dq)
    );

    sram_model i_sram (
        .pins (sram),
        .dq   (sram_dq)
    );

    always #4 clk = ~clk;

    task automatic add_row(string name, kind_t kind, logic [reg_len-1:0] alu_res,
                           logic [reg_len-1:0] val_rm, logic [reg_addr_len-1:0] dest,
                           logic wb_en, int extra);
        row_t r;
        r = '{kind: kind, alu_res: alu_res, val_rm: val_rm, dest: dest,
              wb_en: wb_en, extra: extra};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        //      name           kind        alu_res        val_rm         dest   wb    extra
        add_row("alu_plain",   kind_alu,   32'h1234_5678, 32'h0000_0000, 4'd3,  1'b1, 0);
        add_row("alu_no_wb",   kind_alu,   32'hdead_beef, 32'h0000_0000, 4'd7,  1'b0, 0);
        add_row("store_a",     kind_store, 32'h0000_0100, 32'hcafe_f00d, 4'd0,  1'b0, 0);
        add_row("load_a",      kind_load,  32'h0000_0100, 32'h0000_0000, 4'd5,  1'b1, 0);
        add_row("alu_frz2",    kind_alu,   32'h0bad_c0de, 32'h0000_0000, 4'd9,  1'b1, 2);
        add_row("store_rnd",   kind_store, open_val,      open_val,      4'd0,  1'b0, 0);
        add_row("load_rnd",    kind_load,  open_val,      32'h0000_0000, 4'd12, 1'b1, 0);
        add_row("store_top",   kind_store, 32'h0007_fffc, 32'h8000_0001, 4'd0,  1'b0, 0);
        add_row("load_top",    kind_load,  32'h0007_fffc, 32'h0000_0000, 4'd15, 1'b1, 0);
        add_row("alu_frz5",    kind_alu,   32'h0000_0000, 32'h0000_0000, 4'd1,  1'b1, 5);
        add_row("store_ovr",   kind_store, 32'h0000_0100, 32'h0123_4567, 4'd0,  1'b0, 0);
        add_row("alu_between", kind_alu,   32'h0000_0040, 32'h0000_0000, 4'd2,  1'b1, 1);
        add_row("load_ovr",    kind_load,  32'h0000_0100, 32'h0000_0000, 4'd6,  1'b0, 0);
        add_row("store_rnd2",  kind_store, open_val,      open_val,      4'd0,  1'b0, 0);
        add_row("load_rnd2",   kind_load,  open_val,      32'h0000_0000, 4'd11, 1'b1, 0);
    endtask

    task automatic check_stage_out(string name, stage_out_t exp, stage_out_t act);
        if (act !== exp) begin
            $display("MISMATCH %s stage_out expected %h actual %h", name, exp, act);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_hazard(string name, hazard_t exp, hazard_t act);
        if (act !== exp) begin
            $display("MISMATCH %s hazard expected %h actual %h", name, exp, act);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_pins(string name, sram_pins_t exp, sram_pins_t act);
        if (act !== exp) begin
            $display("MISMATCH %s sram pins expected %h actual %h", name, exp, act);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_reset();
        sram_pins_t act_pins;
        row_errors = 0;
        @(negedge clk);
        check_stage_out("reset", '0, stage_out);
        act_pins      = sram;
        act_pins.addr = '0;  // Address is don't care while idle
        check_pins("reset", '{addr: '0, ub_n: 1'b1, lb_n: 1'b1, we_n: 1'b1,
                              ce_n: 1'b1, oe_n: 1'b1}, act_pins);
        if (ready !== 1'b1) begin
            $display("reset: ready is not high after reset");
            errors++;
            row_errors++;
        end
        $display("reset: %s", (row_errors == 0) ? "passed" : "failed");
        @(posedge clk);
        #1;
    endtask

    task automatic run_row(int idx);
        row_t        r;
        string       name;
        stage_out_t  exp_out;
        hazard_t     exp_hz;
        sram_pins_t  exp_pins;
        sram_pins_t  act_pins;
        logic [16:0] word_idx;
        logic        is_mem;
        logic        ready_seen;
        logic        done;
        int          cyc;
        int          low_cycles;
        int          frz_left;
        int          exp_low;
        r          = rows[idx];
        name       = names[idx];
        row_errors = 0;
        if (r.alu_res == open_val) begin
            r.alu_res = (r.kind == kind_load) ? last_store_addr : ($urandom & 32'h0007_fffc);
        end
        if (r.val_rm == open_val) begin
            r.val_rm = $urandom;
        end
        if (r.kind == kind_store) begin
            last_store_addr = r.alu_res;
        end
        is_mem   = (r.kind != kind_alu);
        word_idx = r.alu_res[18:2];
        exp_hz   = '{wb_en: r.wb_en, dest: r.dest};
        stage_in = '{wb_en: r.wb_en, mem_r_en: r.kind == kind_load,
                     mem_w_en: r.kind == kind_store, alu_res: r.alu_res,
                     val_rm: r.val_rm, dest: r.dest};
        frz_left     = r.extra;
        extra_freeze = (frz_left > 0);
        cyc          = 0;
        low_cycles   = 0;
        done         = 1'b0;
        while (!done) begin
            @(negedge clk);
            check_hazard(name, exp_hz, hazard);
            act_pins = sram;
            if (is_mem && cyc >= 1 && cyc < access_cycles) begin
                // Low half first, then high half, each held for one phase
                exp_pins = '{addr: {word_idx, cyc > sram_phase_cycles}, ub_n: 1'b0,
                             lb_n: 1'b0, we_n: r.kind != kind_store, ce_n: 1'b0,
                             oe_n: r.kind == kind_store};
            end else begin
                exp_pins = '{addr: '0, ub_n: 1'b1, lb_n: 1'b1, we_n: 1'b1,
                             ce_n: 1'b1, oe_n: 1'b1};
                act_pins.addr = '0;
            end
            check_pins(name, exp_pins, act_pins);
            ready_seen = (ready === 1'b1);
            if (!ready_seen) begin
                low_cycles++;
            end
            done = ready_seen && (frz_left == 0);  // Freeze low, register loads
            if (!done) begin
                check_stage_out(name, exp_prev, stage_out);
            end
            @(posedge clk);
            #1;
            if (!done && ready_seen && frz_left > 0) begin
                frz_left--;
                extra_freeze = (frz_left > 0);
            end
            cyc++;
        end
        if (r.kind == kind_store) begin
            shadow[word_idx] = r.val_rm;
            if (i_sram.mem[{word_idx, 1'b0}] !== r.val_rm[15:0]
                || i_sram.mem[{word_idx, 1'b1}] !== r.val_rm[31:16]) begin
                $display("MISMATCH %s sram halves expected %h %h actual %h %h", name,
                         r.val_rm[31:16], r.val_rm[15:0],
                         i_sram.mem[{word_idx, 1'b1}], i_sram.mem[{word_idx, 1'b0}]);
                errors++;
                row_errors++;
            end
        end else if (r.kind == kind_load) begin
            if (shadow.exists(word_idx)) begin
                last_load = shadow[word_idx];
            end else begin
                $display("%s: load from a word that no store has written", name);
                errors++;
                row_errors++;
            end
        end
        exp_low = is_mem ? access_cycles : 0;
        if (low_cycles != exp_low) begin
            $display("MISMATCH %s ready low cycles expected %0d actual %0d",
                     name, exp_low, low_cycles);
            errors++;
            row_errors++;
        end
        exp_out = '{wb_en: r.wb_en, mem_r_en: r.kind == kind_load, alu_res: r.alu_res,
                    mem_res: last_load, dest: r.dest};
        check_stage_out(name, exp_out, stage_out);
        exp_prev = exp_out;
        $display("%s: %s", name, (row_errors == 0) ? "passed" : "failed");
    endtask

    initial begin : watchdog
        int cycles;
        wait (cycle_limit > 0);
        for (cycles = 0; cycles < cycle_limit; cycles++) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, the stage never finished", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int max_extra;
        void'($urandom(32'h69dd3580));
        clk             = 1'b0;
        reset           = 1'b1;
        extra_freeze    = 1'b0;
        stage_in        = '0;
        exp_prev        = '0;
        last_load       = '0;
        last_store_addr = '0;
        errors          = 0;
        row_errors      = 0;
        cycle_limit     = 0;
        build_table();
        max_extra = 0;
        foreach (rows[i]) begin
            if (rows[i].extra > max_extra) begin
                max_extra = rows[i].extra;
            end
        end
        cycle_limit = rows.size() * (access_cycles + max_extra + 4) * 2;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset();
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("Tests run: %0d, failing checks: %0d", rows.size() + 1, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/mem_stage_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage_properties import mem_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       ready,
    input sram_pins_t sram
);

    int low_run;  // Consecutive cycles with ready low

    always_ff @(posedge clk) begin
        if (reset) begin
            low_run <= 0;
        end else if (!ready) begin
            low_run <= low_run + 1;
        end else begin
            low_run <= 0;
        end
    end

    // Bus never driven and read at once
    bus_dir: assert property (@(posedge clk) disable iff (reset)
        !(!sram.we_n && !sram.oe_n))
        else $error("SRAM we_n and oe_n are both low");

    // Pins trail ready by one cycle
    chip_enabled: assert property (@(posedge clk) disable iff (reset)
        (!ready && $past(!ready)) |-> !sram.ce_n)
        else $error("SRAM ce_n high while an access is in progress");

    busy_length: assert property (@(posedge clk) disable iff (reset)
        $rose(ready) |-> (low_run == access_cycles))
        else $error("ready low for %0d cycles, expected %0d", low_run, access_cycles);

endmodule

bind mem_stage_top mem_stage_properties i_properties (
    .clk   (clk),
    .reset (reset),
    .ready (ready),
    .sram  (sram)
);

`default_nettype wire

// ==== test/sram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_model import mem_pkg::*; (
    input  sram_pins_t               pins,
    inout  wire  [sram_data_len-1:0] dq
);

    logic [sram_data_len-1:0] mem [0:(1 << sram_addr_len) - 1];
    logic                     reading;

    assign reading = !pins.ce_n && !pins.oe_n && pins.we_n;
    assign dq      = reading ? mem[pins.addr] : 'z;  // Asynchronous read

    initial begin
        logic [sram_addr_len-1:0] a;
        // Fill pattern mixes every address bit
        for (int i = 0; i < (1 << sram_addr_len); i++) begin
            a      = sram_addr_len'(i);
            mem[a] = sram_data_len'(i ^ (i >> 5));
        end
        // Level-sensitive write, taken once the pins have settled
        forever begin
            @(pins or dq);
            #1;
            if (!pins.ce_n && !pins.we_n) begin
                if (!pins.lb_n) begin
                    mem[pins.addr][7:0] = dq[7:0];
                end
                if (!pins.ub_n) begin
                    mem[pins.addr][15:8] = dq[15:8];  // Upper byte lane
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     freeze,
    input  stage_in_t                stage_in,
    output stage_out_t               stage_out,
    output hazard_t                  hazard,
    output logic                     ready,
    output sram_pins_t               sram,
    inout  wire  [sram_data_len-1:0] sram_dq
);

    sram_ctrl_t         ctrl;
    logic [reg_len-1:0] mem_res;

    // Same-cycle forward to the hazard unit
    assign hazard.wb_en = stage_in.wb_en;
    assign hazard.dest  = stage_in.dest;

    mem_sequencer i_sequencer (
        .clk      (clk),
        .reset    (reset),
        .stage_in (stage_in),
        .ctrl     (ctrl),
        .ready    (ready)
    );

    sram_port i_sram_port (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .alu_res (stage_in.alu_res),  // Byte address
        .val_rm  (stage_in.val_rm),
        .sram    (sram),
        .sram_dq (sram_dq)
    );

    word_assembler i_word_assembler (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .sram_dq (sram_dq),
        .mem_res (mem_res)
    );

    // MEM/WB register
    mem_stage_reg i_stage_reg (
        .clk       (clk),
        .reset     (reset),
        .freeze    (freeze),
        .stage_in  (stage_in),
        .mem_res   (mem_res),
        .stage_out (stage_out)
    );

endmodule

`default_nettype wire

// ==== logic/mem_stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage_reg import mem_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               freeze,
    input  stage_in_t          stage_in,
    input  logic [reg_len-1:0] mem_res,
    output stage_out_t         stage_out
);

    stage_out_t stage_d;

    // Fields that survive into write back
    assign stage_d = '{
        wb_en:    stage_in.wb_en,
        mem_r_en: stage_in.mem_r_en,
        alu_res:  stage_in.alu_res,
        mem_res:  mem_res,
        dest:     stage_in.dest
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_out <= '0;
        end else if (!freeze) begin
            stage_out <= stage_d;
        end
        // Freeze holds the previous instruction
    end

endmodule

`default_nettype wire

// ==== logic/word_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_assembler import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  sram_ctrl_t               ctrl,
    input  logic [sram_data_len-1:0] sram_dq,
    output logic [reg_len-1:0]       mem_res
);

    mem_word_u load_word;
    logic      half_q;  // Half currently on the pins

    // half_sel is one cycle ahead of the pins; delay it to match the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            half_q <= 1'b0;
        end else begin
            half_q <= ctrl.half_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_word.word <= '0;
        end else if (ctrl.capture) begin
            if (half_q) begin
                load_word.half.hi <= sram_dq;  // Odd halfword address
            end else begin
                load_word.half.lo <= sram_dq;  // Even halfword address
            end
        end
    end

    // Whole word valid after the high half lands
    assign mem_res = load_word.word;

endmodule

`default_nettype wire

// ==== logic/sram_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_port import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  sram_ctrl_t               ctrl,
    input  logic [reg_len-1:0]       alu_res,
    input  logic [reg_len-1:0]       val_rm,
    output sram_pins_t               sram,
    inout  wire  [sram_data_len-1:0] sram_dq
);

    mem_word_u                store_word;
    logic [sram_addr_len-1:0] addr_q;
    logic [sram_data_len-1:0] dq_out;
    logic                     dq_oe;
    logic                     ce_n_q;
    logic                     oe_n_q;
    logic                     we_n_q;
    logic                     ub_n_q;
    logic                     lb_n_q;

    assign store_word.word = val_rm;

    // Control pins, all active low
    always_ff @(posedge clk) begin
        if (reset) begin
            ce_n_q <= 1'b1;
            oe_n_q <= 1'b1;
            we_n_q <= 1'b1;
            ub_n_q <= 1'b1;
            lb_n_q <= 1'b1;
            dq_oe  <= 1'b0;
        end else begin
            ce_n_q <= !ctrl.active;
            oe_n_q <= !(ctrl.active && !ctrl.write);
            we_n_q <= !(ctrl.active && ctrl.write);
            ub_n_q <= !ctrl.active;  // Word access, both bytes
            lb_n_q <= !ctrl.active;
            dq_oe  <= ctrl.active && ctrl.write;
        end
    end

    // Halfword address is word address plus half select
    always_ff @(posedge clk) begin
        if (ctrl.active) begin
            addr_q <= {alu_res[sram_addr_len:2], ctrl.half_sel};
            dq_out <= ctrl.half_sel ? store_word.half.hi : store_word.half.lo;
        end
    end

    assign sram = '{addr: addr_q, ub_n: ub_n_q, lb_n: lb_n_q,
                    we_n: we_n_q, ce_n: ce_n_q, oe_n: oe_n_q};

    assign sram_dq = dq_oe ? dq_out : 'z;  // Released unless storing

endmodule

`default_nettype wire

// ==== logic/mem_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_sequencer import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  stage_in_t  stage_in,
    output sram_ctrl_t ctrl,
    output logic       ready
);

    logic [1:0]               state;
    logic [1:0]               state_d;
    logic [phase_cnt_len-1:0] cnt;
    logic [phase_cnt_len-1:0] cnt_d;
    logic                     phase_end;
    logic                     start;
    logic                     write_q;  // Store flag latched at start
    logic                     done_q;   // Access finished last cycle

    assign phase_end = (cnt == phase_cnt_len'(sram_phase_cycles - 1));

    // The finished instruction is still presented in the cycle after completion
    assign start = (state == st_idle) && !done_q
                   && (stage_in.mem_r_en || stage_in.mem_w_en);

    always_comb begin
        state_d = state;
        cnt_d   = cnt;
        case (state)
            st_idle: begin
                if (start) begin
                    state_d = st_low;
                    cnt_d   = '0;
                end
            end
            st_low: begin
                if (phase_end) begin
                    state_d = st_high;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt + 1'b1;
                end
            end
            st_high: begin
                if (phase_end) begin
                    state_d = st_idle;  // Back to idle, pins drop next cycle
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt + 1'b1;
                end
            end
            default: begin
                state_d = st_idle;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            cnt     <= '0;
            write_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state  <= state_d;
            cnt    <= cnt_d;
            done_q <= (state == st_high) && phase_end;
            if (start) begin
                write_q <= stage_in.mem_w_en;
            end
        end
    end

    // ctrl leads the pins by one cycle, so it follows the next state;
    // the registered state then lines up with what the SRAM sees
    assign ctrl.active   = (state_d != st_idle);
    assign ctrl.write    = start ? stage_in.mem_w_en : write_q;
    assign ctrl.half_sel = (state_d == st_high);
    assign ctrl.capture  = (state != st_idle) && !write_q && phase_end;  // End of read phase

    assign ready = (state == st_idle) && !start;

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int reg_len           = 32;
    localparam int reg_addr_len      = 4;
    localparam int sram_addr_len     = 18;
    localparam int sram_data_len     = 16;
    localparam int sram_phase_cycles = 2;  // Cycles the pins hold per halfword
    // Two halfword phases plus the pin register
    localparam int access_cycles     = 2 * sram_phase_cycles + 1;
    localparam int phase_cnt_len     = (sram_phase_cycles > 1) ? $clog2(sram_phase_cycles) : 1;

    // Sequencer state codes
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_low  = 2'd1;
    localparam logic [1:0] st_high = 2'd2;

    typedef struct packed {
        logic                    wb_en;
        logic                    mem_r_en;
        logic                    mem_w_en;
        logic [reg_len-1:0]      alu_res;
        logic [reg_len-1:0]      val_rm;   // Store data
        logic [reg_addr_len-1:0] dest;
    } stage_in_t;

    typedef struct packed {
        logic                    wb_en;
        logic                    mem_r_en;
        logic [reg_len-1:0]      alu_res;
        logic [reg_len-1:0]      mem_res;
        logic [reg_addr_len-1:0] dest;
    } stage_out_t;

    typedef struct packed {
        logic                    wb_en;
        logic [reg_addr_len-1:0] dest;
    } hazard_t;

    typedef struct packed {
        logic [sram_addr_len-1:0] addr;
        logic                     ub_n;
        logic                     lb_n;
        logic                     we_n;
        logic                     ce_n;
        logic                     oe_n;
    } sram_pins_t;

    typedef struct packed {
        logic active;
        logic write;
        logic half_sel;  // 0 low half, 1 high half
        logic capture;   // Read half valid on the bus
    } sram_ctrl_t;

    typedef struct packed {
        logic [sram_data_len-1:0] hi;
        logic [sram_data_len-1:0] lo;
    } half_pair_t;

    // One memory word, seen whole or as two SRAM halfwords
    typedef union packed {
        logic [reg_len-1:0] word;
        half_pair_t         half;
    } mem_word_u;

endpackage

`default_nettype wire
